// ==== Bender.yml ====
package:
  name: rv_core_slice

sources:
  - design/rv_pkg.sv
  - design/rv_regfile.sv
  - design/rv_controller.sv
  - design/rv_imm_extend.sv
  - design/rv_decode_stage.sv
  - design/rv_execute_stage.sv
  - design/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_clk_gen.sv
      - sim/rv_core_monitor.sv
      - sim/rv_core_checker.sv
      - sim/rv_core_tb.sv

// ==== design/rv_controller.sv ====
// Main and ALU decoders producing control signals from the instruction word
`timescale 1ns/1ps
`default_nettype none

module rv_controller (
    input  wire rv_pkg::instr_u   i_instr,
    output rv_pkg::ctrl_t         o_ctrl,
    output rv_pkg::imm_src_e      o_imm_src
);

    logic alu_dec;
    logic sub_en;

    // Main decoder
    always_comb begin
        o_ctrl    = '0;
        o_imm_src = rv_pkg::IMM_I;
        alu_dec   = 1'b0;
        sub_en    = 1'b0;
        case (i_instr.r.opcode)
            rv_pkg::OP_R: begin
                o_ctrl.regwrite = 1'b1;
                alu_dec         = 1'b1;
                // Only register form has sub
                sub_en          = i_instr.r.funct7[5];
            end
            rv_pkg::OP_IALU: begin
                o_ctrl.regwrite = 1'b1;
                o_ctrl.alu_src  = 1'b1;
                alu_dec         = 1'b1;
            end
            rv_pkg::OP_LUI: begin
                o_ctrl.regwrite = 1'b1;
                o_ctrl.res_src  = rv_pkg::RES_IMM;
                o_ctrl.alu_op   = rv_pkg::ALU_PASS_B;
                o_ctrl.alu_src  = 1'b1;
                o_imm_src       = rv_pkg::IMM_U;
            end
            rv_pkg::OP_BRANCH: begin
                // Compare by subtraction, funct3 bit 0 picks bne
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = i_instr.r.funct3[0];
                o_ctrl.alu_op    = rv_pkg::ALU_SUB;
                o_imm_src        = rv_pkg::IMM_B;
            end
            rv_pkg::OP_JAL: begin
                o_ctrl.regwrite = 1'b1;
                o_ctrl.res_src  = rv_pkg::RES_PC4;
                o_ctrl.jump     = 1'b1;
                o_imm_src       = rv_pkg::IMM_J;
            end
            rv_pkg::OP_JALR: begin
                // ALU forms rs1 + imm as the target
                o_ctrl.regwrite = 1'b1;
                o_ctrl.res_src  = rv_pkg::RES_PC4;
                o_ctrl.alu_src  = 1'b1;
                o_ctrl.jump     = 1'b1;
                o_ctrl.jalr     = 1'b1;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase

        // ALU decoder
        if (alu_dec) begin
            case (i_instr.r.funct3)
                3'b000:  o_ctrl.alu_op = sub_en ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'b010:  o_ctrl.alu_op = rv_pkg::ALU_SLT;
                3'b110:  o_ctrl.alu_op = rv_pkg::ALU_OR;
                3'b111:  o_ctrl.alu_op = rv_pkg::ALU_AND;
                default: o_ctrl.alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
// RV32I core slice top joining decode, execute and the register file under one stall
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter int PC_WIDTH = 12
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_in_valid,
    input  wire rv_pkg::instr_u      i_in_instr,
    input  wire logic [PC_WIDTH-1:0] i_in_pc,
    output logic                     o_in_ready,
    output logic                     o_ret_valid,
    output rv_pkg::ex_wb_t           o_ret,
    input  wire logic                i_ret_ready,
    output logic                     o_redir_valid,
    output logic      [PC_WIDTH-1:0] o_redir_pc
);

    rv_pkg::id_ex_t id_ex;
    logic           advance;
    logic           flush;
    logic           rf_we;
    logic [4:0]     raddr1;
    logic [4:0]     raddr2;
    logic [31:0]    rdata1;
    logic [31:0]    rdata2;

    // Whole pipeline moves when the retire slot drains or is empty
    assign advance    = i_ret_ready | ~o_ret_valid;
    assign o_in_ready = advance;

    // Commit on the retire handshake
    assign rf_we = o_ret_valid & i_ret_ready & o_ret.regwrite & (o_ret.rd != 5'd0);

    rv_decode_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_advance  (advance),
        .i_flush    (flush),
        .i_in_valid (i_in_valid),
        .i_in_instr (i_in_instr),
        .i_in_pc    (i_in_pc),
        .i_rdata1   (rdata1),
        .i_rdata2   (rdata2),
        .o_raddr1   (raddr1),
        .o_raddr2   (raddr2),
        .o_id_ex    (id_ex)
    );

    rv_execute_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_advance     (advance),
        .i_id_ex       (id_ex),
        .o_flush       (flush),
        .o_redir_valid (o_redir_valid),
        .o_redir_pc    (o_redir_pc),
        .o_ret_valid   (o_ret_valid),
        .o_ret         (o_ret)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_we     (rf_we),
        .i_waddr  (o_ret.rd),
        .i_wdata  (o_ret.wdata),
        .i_raddr1 (raddr1),
        .i_raddr2 (raddr2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

endmodule

`default_nettype wire

// ==== design/rv_decode_stage.sv ====
// Decode stage with control generation, operand read, immediate and the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage #(
    parameter int PC_WIDTH = 12
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_advance,
    input  wire logic                i_flush,
    input  wire logic                i_in_valid,
    input  wire rv_pkg::instr_u      i_in_instr,
    input  wire logic [PC_WIDTH-1:0] i_in_pc,
    input  wire logic [31:0]         i_rdata1,
    input  wire logic [31:0]         i_rdata2,
    output logic      [4:0]          o_raddr1,
    output logic      [4:0]          o_raddr2,
    output rv_pkg::id_ex_t           o_id_ex
);

    rv_pkg::ctrl_t       ctrl;
    rv_pkg::imm_src_e    imm_src;
    logic [31:0]         imm;
    logic [PC_WIDTH-1:0] pc_plus4;
    logic                squash_pend;
    logic                squash_now;

    // Register addresses straight from the R view
    assign o_raddr1 = i_in_instr.r.rs1;
    assign o_raddr2 = i_in_instr.r.rs2;

    assign pc_plus4   = i_in_pc + PC_WIDTH'(4);
    assign squash_now = i_flush | squash_pend;

    rv_controller u_controller (
        .i_instr   (i_in_instr),
        .o_ctrl    (ctrl),
        .o_imm_src (imm_src)
    );

    rv_imm_extend u_imm_extend (
        .i_instr   (i_in_instr),
        .i_imm_src (imm_src),
        .o_imm     (imm)
    );

    // Redirect seen with no input accepted, kill the next one instead
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            squash_pend <= 1'b0;
        end else if (i_advance) begin
            squash_pend <= squash_now & ~i_in_valid;
        end
    end

    // Decode-to-execute register, frozen under stall
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (i_advance) begin
            o_id_ex.valid    <= i_in_valid & ~squash_now;
            o_id_ex.ctrl     <= ctrl;
            o_id_ex.rs1_data <= i_rdata1;
            o_id_ex.rs2_data <= i_rdata2;
            o_id_ex.rs1_addr <= i_in_instr.r.rs1;
            o_id_ex.rs2_addr <= i_in_instr.r.rs2;
            o_id_ex.rd_addr  <= i_in_instr.r.rd;
            o_id_ex.imm      <= imm;
            o_id_ex.pc       <= 32'(i_in_pc);
            o_id_ex.pc4      <= 32'(pc_plus4);
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_execute_stage.sv ====
// Execute stage with forwarding, ALU, branch and jump resolution and the retire register
`timescale 1ns/1ps
`default_nettype none

module rv_execute_stage #(
    parameter int PC_WIDTH = 12
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_advance,
    input  wire rv_pkg::id_ex_t      i_id_ex,
    output logic                     o_flush,
    output logic                     o_redir_valid,
    output logic      [PC_WIDTH-1:0] o_redir_pc,
    output logic                     o_ret_valid,
    output rv_pkg::ex_wb_t           o_ret
);

    logic        fwd1;
    logic        fwd2;
    logic [31:0] op_a;
    logic [31:0] op_rs2;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] target;
    logic [31:0] result;
    logic        zero;
    logic        taken;

    // Previous instruction still sits in the retire register
    assign fwd1 = o_ret_valid && o_ret.regwrite && (i_id_ex.rs1_addr != 5'd0)
                  && (o_ret.rd == i_id_ex.rs1_addr);
    assign fwd2 = o_ret_valid && o_ret.regwrite && (i_id_ex.rs2_addr != 5'd0)
                  && (o_ret.rd == i_id_ex.rs2_addr);

    assign op_a   = fwd1 ? o_ret.wdata : i_id_ex.rs1_data;
    assign op_rs2 = fwd2 ? o_ret.wdata : i_id_ex.rs2_data;
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm : op_rs2;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            rv_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    // Branch outcome from the subtract result
    assign zero  = (alu_res == 32'd0);
    assign taken = i_id_ex.valid &&
                   (i_id_ex.ctrl.jump || (i_id_ex.ctrl.branch && (zero ^ i_id_ex.ctrl.branch_ne)));

    // jalr clears bit 0 of rs1 + imm
    assign target = i_id_ex.ctrl.jalr ? {alu_res[31:1], 1'b0} : i_id_ex.pc + i_id_ex.imm;

    assign o_flush       = taken;
    assign o_redir_valid = taken;
    assign o_redir_pc    = target[PC_WIDTH-1:0];

    always_comb begin
        case (i_id_ex.ctrl.res_src)
            rv_pkg::RES_PC4: result = 32'(i_id_ex.pc4[PC_WIDTH-1:0]);
            rv_pkg::RES_IMM: result = i_id_ex.imm;
            default:         result = alu_res;
        endcase
    end

    // Retire register, bubbles load with valid low
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ret_valid <= 1'b0;
            o_ret       <= '0;
        end else if (i_advance) begin
            o_ret_valid    <= i_id_ex.valid;
            o_ret.regwrite <= i_id_ex.ctrl.regwrite;
            o_ret.rd       <= i_id_ex.rd_addr;
            o_ret.wdata    <= result;
            o_ret.pc       <= i_id_ex.pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_imm_extend.sv ====
// Immediate extender for the I, B, U and J instruction formats
`timescale 1ns/1ps
`default_nettype none

module rv_imm_extend (
    input  wire rv_pkg::instr_u   i_instr,
    input  wire rv_pkg::imm_src_e i_imm_src,
    output logic [31:0]           o_imm
);

    logic [31:0] w;

    assign w = i_instr.raw;

    always_comb begin
        case (i_imm_src)
            rv_pkg::IMM_I: begin
                o_imm = {{20{i_instr.i.imm12[11]}}, i_instr.i.imm12};
            end
            rv_pkg::IMM_B: begin
                // Halfword offset, bit 0 implied zero
                o_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            rv_pkg::IMM_U: begin
                o_imm = {w[31:12], 12'b0};
            end
            rv_pkg::IMM_J: begin
                o_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
// RV32I core slice package with opcodes, ALU and format encodings, and stage records
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported instruction classes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IALU   = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_src_e;

    // Writeback value source
    typedef enum logic [1:0] {
        RES_ALU,
        RES_PC4,
        RES_IMM
    } res_src_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same word seen as R or I format, raw bits for B, U and J
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        logic [31:0] raw;
    } instr_u;

    typedef struct packed {
        logic     regwrite;
        res_src_e res_src;
        alu_op_e  alu_op;
        logic     alu_src;
        logic     branch;
        logic     branch_ne;
        logic     jump;
        logic     jalr;
    } ctrl_t;

    // PC fields at full width, stages use the low PC_WIDTH bits
    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [4:0]  rd_addr;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] pc4;
    } id_ex_t;

    // Retire record
    typedef struct packed {
        logic        regwrite;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic [31:0] pc;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== design/rv_regfile.sv ====
// Register file of 32 by 32 bits, x0 tied to zero, reads bypass the same-cycle write
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_we,
    input  wire logic [4:0]  i_waddr,
    input  wire logic [31:0] i_wdata,
    input  wire logic [4:0]  i_raddr1,
    input  wire logic [4:0]  i_raddr2,
    output logic      [31:0] o_rdata1,
    output logic      [31:0] o_rdata2
);

    // No storage behind x0
    logic [31:0] regs [1:31];

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (i_we && (addr == i_waddr)) begin
            // Write-through, new value seen in the same cycle
            val = i_wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != 5'd0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    always_comb begin
        o_rdata1 = read_port(i_raddr1);
    end

    always_comb begin
        o_rdata2 = read_port(i_raddr2);
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_controller.sv
design/rv_imm_extend.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_core_top.sv
sim/rv_clk_gen.sv
sim/rv_core_monitor.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

// ==== sim/rv_clk_gen.sv ====
// Clock and reset generator for the core testbench
`timescale 1ns/1ps
`default_nettype none

module rv_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset released just after a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/rv_core_checker.sv ====
// Handshake and reset assertions bound into the core top level
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
    input wire logic           i_clk,
    input wire logic           i_rst_n,
    input wire logic           i_ret_valid,
    input wire rv_pkg::ex_wb_t i_ret,
    input wire logic           i_ret_ready,
    input wire logic           i_redir_valid
);

    // Held record must not change before the handshake
    ret_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ret_valid && !i_ret_ready) |=> (i_ret_valid && $stable(i_ret)))
        else $error("retire record changed while stalled");

    ret_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_ret_valid)
        else $error("retire valid high in reset");

    redir_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_redir_valid)
        else $error("redirect valid high in reset");

endmodule

bind rv_core_top rv_core_checker u_checker (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_ret_valid   (o_ret_valid),
    .i_ret         (o_ret),
    .i_ret_ready   (i_ret_ready),
    .i_redir_valid (o_redir_valid)
);

`default_nettype wire

// ==== sim/rv_core_monitor.sv ====
// Monitor comparing retire records and redirects against the testbench table
`timescale 1ns/1ps
`default_nettype none

module rv_core_monitor #(
    parameter int NUM      = 24,
    parameter int PC_WIDTH = 12
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_in_ready,
    input  wire logic                i_ret_valid,
    input  wire rv_pkg::ex_wb_t      i_ret,
    input  wire logic                i_ret_ready,
    input  wire logic                i_redir_valid,
    input  wire logic [PC_WIDTH-1:0] i_redir_pc,
    output logic                     o_done,
    output int                       o_errors,
    output int                       o_passed
);

    int ret_idx;
    int redir_idx;

    initial begin
        ret_idx   = 0;
        redir_idx = 0;
        o_errors  = 0;
        o_passed  = 0;
        o_done    = 1'b0;
    end

    task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp, act);
        o_errors++;
    endtask

    task automatic check_retire();
        int bad;
        bad = o_errors;
        // Squashed entries never show up on the retire stream
        while (ret_idx < NUM && rv_core_tb.tbl[ret_idx].squash) begin
            $display("entry %0d squashed as expected", ret_idx);
            o_passed++;
            ret_idx++;
        end
        if (ret_idx >= NUM) begin
            $display("Extra retire record at t=%0t beyond the end of the table", $time);
            o_errors++;
        end else begin
            if (i_ret.pc != 32'(rv_core_tb.tbl[ret_idx].pc))
                mismatch("o_ret.pc", 32'(rv_core_tb.tbl[ret_idx].pc), i_ret.pc);
            if (i_ret.regwrite != rv_core_tb.tbl[ret_idx].wr)
                mismatch("o_ret.regwrite", 32'(rv_core_tb.tbl[ret_idx].wr), 32'(i_ret.regwrite));
            if (rv_core_tb.tbl[ret_idx].wr) begin
                if (i_ret.rd != rv_core_tb.tbl[ret_idx].rd)
                    mismatch("o_ret.rd", 32'(rv_core_tb.tbl[ret_idx].rd), 32'(i_ret.rd));
                if (i_ret.wdata != rv_core_tb.tbl[ret_idx].wdata)
                    mismatch("o_ret.wdata", rv_core_tb.tbl[ret_idx].wdata, i_ret.wdata);
            end
            // Taken branch or jump pulses its redirect before it retires
            if (rv_core_tb.tbl[ret_idx].redir && redir_idx <= ret_idx) begin
                $display("Entry %0d retired at t=%0t without its redirect", ret_idx, $time);
                o_errors++;
            end
            if (o_errors == bad) begin
                $display("entry %0d retired ok", ret_idx);
                o_passed++;
            end else begin
                $display("entry %0d retired with errors", ret_idx);
            end
            ret_idx++;
        end
        o_done = (ret_idx >= NUM);
    endtask

    task automatic check_redirect();
        while (redir_idx < NUM && !rv_core_tb.tbl[redir_idx].redir) redir_idx++;
        if (redir_idx >= NUM) begin
            $display("Redirect at t=%0t with no taken branch or jump pending", $time);
            o_errors++;
        end else begin
            if (i_redir_pc != rv_core_tb.tbl[redir_idx].tgt)
                mismatch("o_redir_pc", 32'(rv_core_tb.tbl[redir_idx].tgt), 32'(i_redir_pc));
            redir_idx++;
        end
    endtask

    // Sample mid-cycle where inputs are settled for the coming edge
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (i_redir_valid && i_in_ready) check_redirect();
            if (i_ret_valid && i_ret_ready) check_retire();
        end
    end

endmodule

`default_nettype wire

// ==== sim/rv_core_tb.sv ====
// Testbench top driving an instruction table through the core under random stalls
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int PC_WIDTH = 12;
    localparam int NUM      = 24;
    localparam int LIMIT    = NUM * 40;

    typedef struct packed {
        logic [31:0] instr;
        logic [11:0] pc;
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        redir;
        logic [11:0] tgt;
        logic        squash;
    } entry_t;

    entry_t tbl [NUM];

    logic                clk;
    logic                rst_n;
    logic                i_in_valid;
    rv_pkg::instr_u      i_in_instr;
    logic [PC_WIDTH-1:0] i_in_pc;
    logic                o_in_ready;
    logic                o_ret_valid;
    rv_pkg::ex_wb_t      o_ret;
    logic                i_ret_ready;
    logic                o_redir_valid;
    logic [PC_WIDTH-1:0] o_redir_pc;
    logic                done;
    int                  errors;
    int                  passed;
    logic [31:0]         gap_state;
    logic [31:0]         rdy_state;

    rv_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    rv_core_top #(.PC_WIDTH(PC_WIDTH)) u_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_in_valid    (i_in_valid),
        .i_in_instr    (i_in_instr),
        .i_in_pc       (i_in_pc),
        .o_in_ready    (o_in_ready),
        .o_ret_valid   (o_ret_valid),
        .o_ret         (o_ret),
        .i_ret_ready   (i_ret_ready),
        .o_redir_valid (o_redir_valid),
        .o_redir_pc    (o_redir_pc)
    );

    rv_core_monitor #(.NUM(NUM), .PC_WIDTH(PC_WIDTH)) u_monitor (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_in_ready    (o_in_ready),
        .i_ret_valid   (o_ret_valid),
        .i_ret         (o_ret),
        .i_ret_ready   (i_ret_ready),
        .i_redir_valid (o_redir_valid),
        .i_redir_pc    (o_redir_pc),
        .o_done        (done),
        .o_errors      (errors),
        .o_passed      (passed)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic entry_t alu_entry(input logic [31:0] instr, input logic [11:0] pc,
                                         input logic [4:0] rd, input logic [31:0] wdata);
        return '{instr, pc, 1'b1, rd, wdata, 1'b0, 12'h0, 1'b0};
    endfunction

    function automatic entry_t branch_entry(input logic [31:0] instr, input logic [11:0] pc,
                                            input logic taken, input logic [11:0] tgt);
        return '{instr, pc, 1'b0, 5'd0, 32'h0, taken, tgt, 1'b0};
    endfunction

    function automatic entry_t jump_entry(input logic [31:0] instr, input logic [11:0] pc,
                                          input logic [4:0] rd, input logic [11:0] tgt);
        return '{instr, pc, 1'b1, rd, 32'(pc + 12'd4), 1'b1, tgt, 1'b0};
    endfunction

    function automatic entry_t squashed_entry(input logic [31:0] instr, input logic [11:0] pc);
        return '{instr, pc, 1'b0, 5'd0, 32'h0, 1'b0, 12'h0, 1'b1};
    endfunction

    task automatic build_table();
        tbl[0]  = alu_entry(enc_i(12'd5, 5'd0, 3'b000, 5'd1, rv_pkg::OP_IALU), 12'h000, 5'd1, 32'd5);
        tbl[1]  = alu_entry(enc_i(12'hFFD, 5'd0, 3'b000, 5'd2, rv_pkg::OP_IALU), 12'h004, 5'd2,
                            32'hFFFF_FFFD);
        tbl[2]  = alu_entry(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 12'h008, 5'd3, 32'd2);
        tbl[3]  = alu_entry(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 12'h00C, 5'd4, 32'hFFFF_FFFD);
        tbl[4]  = alu_entry(enc_r(7'h00, 5'd1, 5'd4, 3'b111, 5'd5), 12'h010, 5'd5, 32'd5);
        tbl[5]  = alu_entry(enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6), 12'h014, 5'd6, 32'hFFFF_FFFD);
        tbl[6]  = alu_entry(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd7), 12'h018, 5'd7, 32'd1);
        tbl[7]  = alu_entry({20'h12345, 5'd8, rv_pkg::OP_LUI}, 12'h01C, 5'd8, 32'h1234_5000);
        tbl[8]  = alu_entry(enc_i(12'd7, 5'd0, 3'b000, 5'd0, rv_pkg::OP_IALU), 12'h020, 5'd0, 32'd7);
        // x0 must still read zero here
        tbl[9]  = alu_entry(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd9), 12'h024, 5'd9, 32'd5);
        tbl[10] = alu_entry(enc_i(12'h678, 5'd8, 3'b110, 5'd10, rv_pkg::OP_IALU), 12'h028, 5'd10,
                            32'h1234_5678);
        tbl[11] = alu_entry(enc_i(12'hFFE, 5'd4, 3'b010, 5'd11, rv_pkg::OP_IALU), 12'h02C, 5'd11,
                            32'd1);
        tbl[12] = branch_entry(enc_b(13'd16, 5'd9, 5'd1, 3'b000), 12'h030, 1'b1, 12'h040);
        tbl[13] = squashed_entry(enc_i(12'd1, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IALU), 12'h034);
        tbl[14] = branch_entry(enc_b(13'd8, 5'd9, 5'd1, 3'b001), 12'h040, 1'b0, 12'h000);
        tbl[15] = branch_entry(enc_b(13'd12, 5'd2, 5'd1, 3'b001), 12'h044, 1'b1, 12'h050);
        tbl[16] = squashed_entry(enc_i(12'd2, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IALU), 12'h048);
        tbl[17] = jump_entry(enc_j(21'd16, 5'd13), 12'h050, 5'd13, 12'h060);
        tbl[18] = squashed_entry(enc_i(12'd3, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IALU), 12'h054);
        tbl[19] = alu_entry(enc_i(12'h100, 5'd0, 3'b000, 5'd14, rv_pkg::OP_IALU), 12'h060, 5'd14,
                            32'h100);
        // Target 0x105 with bit 0 cleared
        tbl[20] = jump_entry(enc_i(12'd5, 5'd14, 3'b000, 5'd15, rv_pkg::OP_JALR), 12'h064, 5'd15,
                             12'h104);
        tbl[21] = squashed_entry(enc_i(12'd4, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IALU), 12'h068);
        tbl[22] = alu_entry(enc_r(7'h00, 5'd13, 5'd15, 3'b000, 5'd16), 12'h104, 5'd16, 32'hBC);
        tbl[23] = alu_entry(enc_r(7'h20, 5'd16, 5'd16, 3'b000, 5'd17), 12'h108, 5'd17, 32'd0);
    endtask

    // Retire back-pressure
    always @(posedge clk) begin
        #1;
        rdy_state   = xorshift(rdy_state);
        i_ret_ready = (rdy_state[1:0] != 2'b00);
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout after %0d cycles, not every entry retired", LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        i_in_valid  = 1'b0;
        i_in_instr  = '0;
        i_in_pc     = '0;
        i_ret_ready = 1'b0;
        gap_state   = 32'h6754;
        rdy_state   = xorshift(32'h6754);
        build_table();
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM; n++) begin
            gap_state = xorshift(gap_state);
            // Random idle cycle on the input stream
            while (gap_state[5:4] == 2'b00) begin
                i_in_valid = 1'b0;
                @(posedge clk);
                #1;
                gap_state = xorshift(gap_state);
            end
            i_in_valid = 1'b1;
            i_in_instr = tbl[n].instr;
            i_in_pc    = tbl[n].pc;
            @(negedge clk);
            while (!o_in_ready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        i_in_valid = 1'b0;
        wait (done);
        repeat (6) @(posedge clk);
        $display("Summary: %0d entries passed, %0d errors", passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
